/* bench/st_mem_patterns.txt */
# columns: op arg1 arg2 expect, all hex; 1 download start(index) 2 host word(data, byte addr, word addr)
# 3 download end 4 chipset random(size, count) 5 rom(selects, cpu addr, rom addr) 6 turbo 7 chipset in download(addr)
6 1 0 0
1 1 0 0
2 5aa5 0 7e0000
2 0f1e 2 7e0001
3 0 0 0
5 0 1abcd 7fabcd
6 0 0 0
1 0 0 0
2 1234 0 700000
2 abcd 2 700001
7 1000 0 0
3 0 0 0
5 0 12345 712345
5 3 12345 12345
5 1 4567 4567
1 2 0 0
2 c0de 0 7d0000
3 0 0 0
1 4 0 0
2 2340 0 0
2 0001 2 0
2 beef 4 12340
2 cafe 6 12341
3 0 0 0
4 0 8 0
4 1 8 0
4 2 8 0
4 3 8 0
4 4 8 0
4 5 8 0

/* project.f */
src/st_mem_pkg.sv
src/mem_port_if.sv
src/upload_loader.sv
src/ram_window.sv
src/rom_mapper.sv
src/mem_arbiter.sv
src/st_mem_top.sv
bench/st_mem_properties.sv
bench/tb_st_mem.sv

/* Makefile */
# Verilator build and run for the ST memory multiplexer

VERILATOR ?= verilator
TOP       := tb_st_mem
FILELIST  := project.f
VFLAGS    := --binary --assert --timing --top-module $(TOP)
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the log holds the pass line
run: $(SIM)
	-$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q '^TEST OK$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/tb_st_mem.sv */
// testbench for the ST memory multiplexer with steps read from the pattern file
// a small reference model predicts every memory write and ROM address
`timescale 1ns/10ps

module tb_st_mem;

	localparam int SLOT_DIV     = 4;
	localparam int RESET_CYCLES = 16;
	localparam int STEP_CYCLES  = 64;
	// one full bus cycle between host strobes
	localparam int HOST_GAP     = 4 * SLOT_DIV;
	// loader words may wait most of a bus cycle for a CPU slot
	localparam int REQ_WAIT     = 3 * HOST_GAP;

	logic        clk_32;
	logic        xsint;
	logic        ioctl_download_i;
	logic        ioctl_wr_i;
	logic [4:0]  ioctl_index_i;
	logic [24:0] ioctl_addr_i;
	logic [15:0] ioctl_dout_i;
	logic        ras_n_i;
	logic        we_n_i;
	logic [22:0] ram_addr_i;
	logic        uds_i;
	logic        lds_i;
	logic [15:0] ram_din_i;
	logic        rom_sel_n_i;
	logic        rom2_sel_n_i;
	logic [22:0] rom_cpu_addr_i;
	logic [22:0] rom_addr_o;
	logic [2:0]  mem_size_i;
	logic        turbo_i;
	logic        mem_req_o;
	logic        mem_we_o;
	logic [22:0] mem_addr_o;
	logic [1:0]  mem_ds_o;
	logic [15:0] mem_din_o;

	int          value_errors;
	int          other_errors;
	int          steps;
	int          cur_line;
	// rising edges since reset release
	int          cyc;
	logic [31:0] rnd_state;
	// reference model state
	logic [4:0]  dl_index;
	logic [22:0] next_addr;
	logic [15:0] ptr_lo;
	logic        tos192k_ref;
	// pattern steps
	logic [31:0] op_q[$];
	logic [31:0] a1_q[$];
	logic [31:0] a2_q[$];
	logic [31:0] ex_q[$];
	int          line_q[$];

	st_mem_top #(.SLOT_DIV(SLOT_DIV)) DUT (.*);

	initial begin
		clk_32 = 1'b0;
		forever #20 clk_32 = ~clk_32;
	end

	// edge count drives the slot timing model
	always @(posedge clk_32) begin
		if (xsint)
			cyc <= cyc + 1;
	end

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	// inputs change 2 ns after the rising edge
	task automatic tick();
		@(posedge clk_32);
		#2;
	endtask

	task automatic report_value(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		value_errors++;
		$display("Error %s (pattern line %0d): expected %h, actual %h",
			name, cur_line, exp, act);
	endtask

	task automatic report_fault(input string what);
		other_errors++;
		$display("pattern line %0d: %s", cur_line, what);
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// first word address of a download from the byte region starts
	function automatic logic [22:0] base_for(input logic [4:0] idx);
		case (idx)
			5'd0:    return 23'(32'hE00000 >> 1);
			5'd1:    return 23'(32'hFC0000 >> 1);
			5'd2:    return 23'(32'hFA0000 >> 1);
			default: return 23'd0;
		endcase
	endfunction

	// RAM size in words where 14M stops at byte E00000
	function automatic bit ram_hit(input logic [2:0] size, input logic [22:0] addr);
		logic [23:0] lim;
		case (size)
			3'd0:    lim = 24'h040000;
			3'd1:    lim = 24'h080000;
			3'd2:    lim = 24'h100000;
			3'd3:    lim = 24'h200000;
			3'd4:    lim = 24'h400000;
			3'd5:    lim = 24'h700000;
			default: lim = 24'h000000;
		endcase
		return (addr != 23'd0) && ({1'b0, addr} < lim);
	endfunction

	// every SLOT_DIV-th edge opens the next slot
	// slot 1 belongs to the CPU and turbo adds slot 2
	function automatic int grant_edge(input int pend_edge, input logic turbo);
		int n;
		int s;
		n = pend_edge + 1;
		s = (n / SLOT_DIV) % 4;
		while (n % SLOT_DIV != 0 || !(s == 1 || (turbo && s == 2))) begin
			n++;
			s = (n / SLOT_DIV) % 4;
		end
		return n;
	endfunction

	task automatic wait_request(input int limit, output bit seen);
		int i;
		seen = 1'b0;
		for (i = 0; i < limit && !seen; i++) begin
			tick();
			seen = mem_req_o;
		end
	endtask

	task automatic load_patterns(output bit ok);
		int          fd;
		int          n;
		int          lineno;
		string       text;
		logic [31:0] op, a1, a2, ex;
		ok = 1'b0;
		lineno = 0;
		fd = $fopen("bench/st_mem_patterns.txt", "r");
		if (fd != 0) begin
			while (!$feof(fd)) begin
				text = "";
				n = $fgets(text, fd);
				lineno++;
				// comment lines fail the scan and drop out
				if (n > 0) begin
					n = $sscanf(text, "%h %h %h %h", op, a1, a2, ex);
					if (n == 4) begin
						op_q.push_back(op);
						a1_q.push_back(a1);
						a2_q.push_back(a2);
						ex_q.push_back(ex);
						line_q.push_back(lineno);
					end
				end
			end
			$fclose(fd);
			ok = (op_q.size() > 0);
		end
	endtask

	////////////////////////////////////////
	// step operations
	////////////////////////////////////////

	task automatic download_start(input logic [4:0] idx);
		ioctl_download_i = 1'b1;
		ioctl_index_i    = idx;
		ioctl_addr_i     = '0;
		dl_index         = idx;
		next_addr        = base_for(idx);
		repeat (2) tick();
	endtask

	task automatic host_write(input logic [15:0] data, input logic [24:0] iaddr,
		input logic [22:0] exp_addr);
		bit custom_ptr;
		bit seen;
		int want_edge;
		custom_ptr = (dl_index == 5'd4) && (iaddr < 25'd4);
		// pointer words carry the low 16 bits and then the high bits
		if (custom_ptr && iaddr == 25'd0)
			ptr_lo = data;
		else if (custom_ptr)
			next_addr = {data[6:0], ptr_lo};
		ioctl_wr_i   = 1'b1;
		ioctl_dout_i = data;
		ioctl_addr_i = iaddr;
		tick();
		ioctl_wr_i = 1'b0;
		if (custom_ptr) begin
			wait_request(REQ_WAIT, seen);
			if (seen)
				report_fault("custom pointer word produced a memory write");
		end else begin
			if (exp_addr !== next_addr)
				report_fault("pattern address disagrees with the reference model");
			// word becomes pending at the next edge
			want_edge = grant_edge(cyc + 1, turbo_i);
			wait_request(REQ_WAIT, seen);
			if (!seen) begin
				report_fault("loader write never reached the memory port");
			end else begin
				if (cyc != want_edge)
					report_value("loader grant edge", 32'(want_edge), 32'(cyc));
				if (mem_we_o !== 1'b1)
					report_value("loader we", 32'(1'b1), 32'(mem_we_o));
				if (mem_addr_o !== next_addr)
					report_value("loader addr", 32'(next_addr), 32'(mem_addr_o));
				if (mem_ds_o !== 2'b11)
					report_value("loader ds", 32'(2'b11), 32'(mem_ds_o));
				if (mem_din_o !== {data[7:0], data[15:8]})
					report_value("loader data", 32'({data[7:0], data[15:8]}), 32'(mem_din_o));
			end
			// FC0000 and up marks a 192K TOS and the E00000 range clears it
			if (next_addr >= 23'h7E0000)
				tos192k_ref = 1'b1;
			else if (next_addr >= 23'h700000 && next_addr < 23'h780000)
				tos192k_ref = 1'b0;
			next_addr = next_addr + 23'd1;
			repeat (HOST_GAP) tick();
		end
	endtask

	task automatic download_end();
		ioctl_download_i = 1'b0;
		repeat (2) tick();
	endtask

	task automatic chipset_access(input logic [22:0] addr, input logic [15:0] din,
		input logic we_n, input logic [1:0] ds, input bit expect_req);
		bit seen;
		int fall_edge;
		ras_n_i    = 1'b0;
		ram_addr_i = addr;
		ram_din_i  = din;
		we_n_i     = we_n;
		uds_i      = ds[1];
		lds_i      = ds[0];
		tick();
		fall_edge = cyc;
		ras_n_i = 1'b1;
		wait_request(4, seen);
		if (expect_req && !seen) begin
			report_fault("in-window chipset access produced no request");
		end else if (!expect_req && seen) begin
			report_fault("unexpected chipset request on the memory port");
		end else if (seen) begin
			if (cyc != fall_edge + 1)
				report_value("chipset grant edge", 32'(fall_edge + 1), 32'(cyc));
			if (mem_addr_o !== addr)
				report_value("chipset addr", 32'(addr), 32'(mem_addr_o));
			if (mem_we_o !== ~we_n)
				report_value("chipset we", 32'(~we_n), 32'(mem_we_o));
			if (mem_ds_o !== ds)
				report_value("chipset ds", 32'(ds), 32'(mem_ds_o));
			if (mem_din_o !== din)
				report_value("chipset data", 32'(din), 32'(mem_din_o));
		end
		repeat (2) tick();
	endtask

	task automatic chipset_burst(input logic [2:0] size, input int count);
		int          k;
		logic [22:0] addr;
		logic [31:0] dat;
		mem_size_i = size;
		for (k = 0; k < count; k++) begin
			rnd_state = xorshift32(rnd_state);
			// random shift spreads addresses over all window sizes
			addr = rnd_state[22:0] >> rnd_state[26:24];
			// now and then a refresh cycle
			if (rnd_state[31:29] == 3'd0)
				addr = 23'd0;
			dat = xorshift32(rnd_state ^ 32'h0000_ffff);
			chipset_access(addr, dat[15:0], rnd_state[27], dat[17:16] | 2'b01,
				ram_hit(size, addr));
		end
	endtask

	task automatic rom_check(input logic [1:0] sel, input logic [22:0] cpu,
		input logic [22:0] exp_rom);
		logic [22:0] want;
		rom_sel_n_i    = sel[1];
		rom2_sel_n_i   = sel[0];
		rom_cpu_addr_i = cpu;
		// ROM2 keeps the low 128K words under the TOS region
		if (sel == 2'b00)
			want = (tos192k_ref ? base_for(5'd1) : base_for(5'd0)) | {6'd0, cpu[16:0]};
		else
			want = cpu;
		#1;
		if (exp_rom !== want)
			report_fault("pattern ROM address disagrees with the reference model");
		if (rom_addr_o !== want)
			report_value("rom addr", 32'(want), 32'(rom_addr_o));
		tick();
		rom_sel_n_i  = 1'b1;
		rom2_sel_n_i = 1'b1;
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial begin
		bit loaded;
		int i;
		xsint            = 1'b0;
		ioctl_download_i = 1'b0;
		ioctl_wr_i       = 1'b0;
		ioctl_index_i    = '0;
		ioctl_addr_i     = '0;
		ioctl_dout_i     = '0;
		ras_n_i          = 1'b1;
		we_n_i           = 1'b1;
		ram_addr_i       = '0;
		uds_i            = 1'b0;
		lds_i            = 1'b0;
		ram_din_i        = '0;
		rom_sel_n_i      = 1'b1;
		rom2_sel_n_i     = 1'b1;
		rom_cpu_addr_i   = '0;
		mem_size_i       = 3'd5;
		turbo_i          = 1'b0;
		value_errors     = 0;
		other_errors     = 0;
		cur_line         = 0;
		cyc              = 0;
		rnd_state        = 32'd30;
		dl_index         = '0;
		next_addr        = '0;
		ptr_lo           = '0;
		tos192k_ref      = 1'b0;
		load_patterns(loaded);
		if (!loaded) begin
			$display("pattern file missing or holds no steps");
			$display("TEST FAILED");
			$finish;
		end else begin
			steps = op_q.size();
			repeat (RESET_CYCLES) tick();
			xsint = 1'b1;
			repeat (2) tick();
			for (i = 0; i < steps; i++) begin
				cur_line = line_q[i];
				case (op_q[i])
					32'h1: download_start(a1_q[i][4:0]);
					32'h2: host_write(a1_q[i][15:0], a2_q[i][24:0], ex_q[i][22:0]);
					32'h3: download_end();
					32'h4: chipset_burst(a1_q[i][2:0], int'(a2_q[i]));
					32'h5: rom_check(a1_q[i][1:0], a2_q[i][22:0], ex_q[i][22:0]);
					32'h6: begin
						turbo_i = a1_q[i][0];
						tick();
					end
					// a chipset access while the host uploads is dropped
					32'h7: chipset_access(a1_q[i][22:0], 16'h5a5a, 1'b0, 2'b11, 1'b0);
					default: report_fault("unknown operation in pattern file");
				endcase
			end
			$display("errors: %0d value, %0d other", value_errors, other_errors);
			if (value_errors + other_errors == 0)
				$display("TEST OK");
			else
				$display("TEST FAILED");
			$finish;
		end
	end

	// watchdog budget grows with the number of steps
	initial begin
		wait (steps > 0);
		repeat (steps * STEP_CYCLES + RESET_CYCLES) @(posedge clk_32);
		$display("watchdog expired, run took longer than %0d cycles",
			steps * STEP_CYCLES + RESET_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

endmodule

/* bench/st_mem_properties.sv */
// concurrent checks on the memory port and ROM outputs
// attached to st_mem_top by the bind at the bottom
`timescale 1ns/10ps

module st_mem_props (
	input logic                   clk_32,
	input logic                   xsint,
	input logic                   download_i,
	input logic                   mem_req_i,
	input logic                   mem_we_i,
	input st_mem_pkg::word_addr_t mem_addr_i,
	input logic [1:0]             mem_ds_i,
	input st_mem_pkg::mem_word_t  mem_din_i,
	input st_mem_pkg::word_addr_t rom_addr_i
);

	// single-cycle strobes only
	req_single: assert property (@(posedge clk_32) disable iff (!xsint)
		mem_req_i |=> !mem_req_i)
		else $error("memory request high for two clocks in a row");

	// host upload owns the port, full word writes
	dl_write: assert property (@(posedge clk_32) disable iff (!xsint)
		(download_i && mem_req_i) |-> (mem_we_i && mem_ds_i == 2'b11))
		else $error("request during download is not a full word write");

	////////////////////////////////////////
	// no X once out of reset
	////////////////////////////////////////

	known_out: assert property (@(posedge clk_32) disable iff (!xsint)
		!$isunknown({mem_req_i, mem_we_i, mem_addr_i, mem_ds_i, mem_din_i, rom_addr_i}))
		else $error("unknown value on a top-level output");

endmodule

bind st_mem_top st_mem_props u_props (
	.clk_32     (clk_32),
	.xsint      (xsint),
	.download_i (download),
	.mem_req_i  (mem_req_o),
	.mem_we_i   (mem_we_o),
	.mem_addr_i (mem_addr_o),
	.mem_ds_i   (mem_ds_o),
	.mem_din_i  (mem_din_o),
	.rom_addr_i (rom_addr_o)
);

/* src/st_mem_top.sv */
// memory side of the ST core: upload loader, chipset RAM window,
// ROM mapper and the slot arbiter on one shared memory port
`timescale 1ns/10ps

module st_mem_top #(
	parameter int unsigned SLOT_DIV = 4
) (
	input  logic                   clk_32,
	input  logic                   xsint,
	// host upload
	input  logic                   ioctl_download_i,
	input  logic                   ioctl_wr_i,
	input  logic [4:0]             ioctl_index_i,
	input  logic [24:0]            ioctl_addr_i,
	input  st_mem_pkg::mem_word_t  ioctl_dout_i,
	// chipset
	input  logic                   ras_n_i,
	input  logic                   we_n_i,
	input  st_mem_pkg::word_addr_t ram_addr_i,
	input  logic                   uds_i,
	input  logic                   lds_i,
	input  st_mem_pkg::mem_word_t  ram_din_i,
	// ROM
	input  logic                   rom_sel_n_i,
	input  logic                   rom2_sel_n_i,
	input  st_mem_pkg::word_addr_t rom_cpu_addr_i,
	output st_mem_pkg::word_addr_t rom_addr_o,
	// configuration
	input  logic [2:0]             mem_size_i,
	input  logic                   turbo_i,
	// memory port
	output logic                   mem_req_o,
	output logic                   mem_we_o,
	output st_mem_pkg::word_addr_t mem_addr_o,
	output logic [1:0]             mem_ds_o,
	output st_mem_pkg::mem_word_t  mem_din_o
);

	logic                   download;
	st_mem_pkg::word_addr_t load_addr;

	mem_port_if loader_port ();
	mem_port_if chipset_port ();

	////////////////////////////////////////
	// requesters
	////////////////////////////////////////

	upload_loader u_loader (
		.clk_32           (clk_32),
		.xsint            (xsint),
		.ioctl_download_i (ioctl_download_i),
		.ioctl_wr_i       (ioctl_wr_i),
		.ioctl_index_i    (ioctl_index_i),
		.ioctl_addr_i     (ioctl_addr_i),
		.ioctl_dout_i     (ioctl_dout_i),
		.download_o       (download),
		.load_addr_o      (load_addr),
		.port             (loader_port.requester)
	);

	ram_window u_window (
		.clk_32     (clk_32),
		.xsint      (xsint),
		.ras_n_i    (ras_n_i),
		.we_n_i     (we_n_i),
		.ram_addr_i (ram_addr_i),
		.uds_i      (uds_i),
		.lds_i      (lds_i),
		.ram_din_i  (ram_din_i),
		.mem_size_i (mem_size_i),
		.port       (chipset_port.requester)
	);

	// ROM side watches the upload address
	rom_mapper u_rom (
		.clk_32         (clk_32),
		.xsint          (xsint),
		.download_i     (download),
		.load_addr_i    (load_addr),
		.rom_sel_n_i    (rom_sel_n_i),
		.rom2_sel_n_i   (rom2_sel_n_i),
		.rom_cpu_addr_i (rom_cpu_addr_i),
		.rom_addr_o     (rom_addr_o)
	);

	mem_arbiter #(
		.SLOT_DIV (SLOT_DIV)
	) u_arb (
		.clk_32     (clk_32),
		.xsint      (xsint),
		.turbo_i    (turbo_i),
		.download_i (download),
		.loader     (loader_port.grant),
		.chipset    (chipset_port.grant),
		.mem_req_o  (mem_req_o),
		.mem_we_o   (mem_we_o),
		.mem_addr_o (mem_addr_o),
		.mem_ds_o   (mem_ds_o),
		.mem_din_o  (mem_din_o)
	);

endmodule

/* src/mem_arbiter.sv */
// shares the memory port between the upload loader and the chipset
// loader words wait for a CPU slot, chipset requests pass straight on
`timescale 1ns/10ps

module mem_arbiter #(
	parameter int unsigned SLOT_DIV = 4
) (
	input  logic                   clk_32,
	input  logic                   xsint,
	input  logic                   turbo_i,
	input  logic                   download_i,
	mem_port_if.grant              loader,
	mem_port_if.grant              chipset,
	output logic                   mem_req_o,
	output logic                   mem_we_o,
	output st_mem_pkg::word_addr_t mem_addr_o,
	output logic [1:0]             mem_ds_o,
	output st_mem_pkg::mem_word_t  mem_din_o
);

	localparam int unsigned CW = (SLOT_DIV > 1) ? $clog2(SLOT_DIV) : 1;

	logic [CW-1:0]          div_cnt;
	logic [1:0]             slot;
	logic [1:0]             slot_nxt;
	logic                   phase_stb;
	logic                   cpu_nxt;
	logic                   ld_pend;
	logic                   ch_pend;
	logic                   ld_go;
	logic                   ch_new;
	logic                   ld_we, ch_we;
	logic [1:0]             ld_ds, ch_ds;
	st_mem_pkg::word_addr_t ld_addr, ch_addr;
	st_mem_pkg::mem_word_t  ld_din, ch_din;

	////////////////////////////////////////
	// slot timer
	////////////////////////////////////////

	assign phase_stb = (div_cnt == CW'(SLOT_DIV - 1));
	assign slot_nxt  = (slot == st_mem_pkg::SLOT_SPARE) ? st_mem_pkg::SLOT_PRE : slot + 2'd1;
	// turbo lends the shifter slot to the CPU
	assign cpu_nxt   = (slot_nxt == st_mem_pkg::SLOT_CPU) ||
	                   (turbo_i && slot_nxt == st_mem_pkg::SLOT_SHIFTER);

	assign ld_go  = ld_pend & phase_stb & cpu_nxt;
	// chipset is shut out while the host uploads
	assign ch_new = chipset.req & ~download_i;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			div_cnt    <= '0;
			slot       <= st_mem_pkg::SLOT_PRE;
			ld_pend    <= 1'b0;
			ch_pend    <= 1'b0;
			mem_req_o  <= 1'b0;
			mem_we_o   <= 1'b0;
			mem_addr_o <= '0;
			mem_ds_o   <= '0;
			mem_din_o  <= '0;
		end else begin
			div_cnt   <= phase_stb ? '0 : div_cnt + 1'b1;
			mem_req_o <= 1'b0;
			if (phase_stb)
				slot <= slot_nxt;
			// loader wins the slot, a colliding chipset access waits a clock
			if (ld_go) begin
				ld_pend    <= 1'b0;
				ch_pend    <= ch_pend | ch_new;
				mem_req_o  <= 1'b1;
				mem_we_o   <= ld_we;
				mem_addr_o <= ld_addr;
				mem_ds_o   <= ld_ds;
				mem_din_o  <= ld_din;
			end else if (ch_new) begin
				mem_req_o  <= 1'b1;
				mem_we_o   <= chipset.we;
				mem_addr_o <= chipset.addr;
				mem_ds_o   <= chipset.ds;
				mem_din_o  <= chipset.din;
			end else if (ch_pend) begin
				ch_pend    <= 1'b0;
				mem_req_o  <= 1'b1;
				mem_we_o   <= ch_we;
				mem_addr_o <= ch_addr;
				mem_ds_o   <= ch_ds;
				mem_din_o  <= ch_din;
			end
			if (loader.req)
				ld_pend <= 1'b1;
		end
	end

	// pending entries, one per requester
	always_ff @(posedge clk_32) begin
		if (loader.req) begin
			ld_we   <= loader.we;
			ld_addr <= loader.addr;
			ld_ds   <= loader.ds;
			ld_din  <= loader.din;
		end
		if (ch_new) begin
			ch_we   <= chipset.we;
			ch_addr <= chipset.addr;
			ch_ds   <= chipset.ds;
			ch_din  <= chipset.din;
		end
	end

endmodule

/* src/rom_mapper.sv */
// ROM address remap, follows whether a 192K TOS was uploaded
// the ROM2 window goes to E00000 or FC0000 accordingly
`timescale 1ns/10ps

module rom_mapper (
	input  logic                   clk_32,
	input  logic                   xsint,
	input  logic                   download_i,
	input  st_mem_pkg::word_addr_t load_addr_i,
	input  logic                   rom_sel_n_i,
	input  logic                   rom2_sel_n_i,
	input  st_mem_pkg::word_addr_t rom_cpu_addr_i,
	output st_mem_pkg::word_addr_t rom_addr_o
);

	logic tos192k;
	logic rom2_hit;

	// upload address decides the TOS flavour
	// FC0000 and up sets, E00000 range clears
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			tos192k <= 1'b0;
		end else if (download_i) begin
			if (load_addr_i[22:17] == st_mem_pkg::BASE_TOS192[22:17])
				tos192k <= 1'b1;
			else if (load_addr_i[22:19] == st_mem_pkg::BASE_TOS256[22:19])
				tos192k <= 1'b0;
		end
	end

	// ROM2 is one of the ROM selects
	assign rom2_hit = ~rom_sel_n_i & ~rom2_sel_n_i;

	// keep the low 128K words, swap the region prefix
	assign rom_addr_o = !rom2_hit ? rom_cpu_addr_i :
	                    tos192k   ? {st_mem_pkg::BASE_TOS192[22:17], rom_cpu_addr_i[16:0]} :
	                                {st_mem_pkg::BASE_TOS256[22:17], rom_cpu_addr_i[16:0]};

endmodule

/* src/ram_window.sv */
// chipset RAM access: row strobe fall starts a request
// refresh and addresses outside the configured size are dropped
`timescale 1ns/10ps

module ram_window (
	input  logic                   clk_32,
	input  logic                   xsint,
	input  logic                   ras_n_i,
	input  logic                   we_n_i,
	input  st_mem_pkg::word_addr_t ram_addr_i,
	input  logic                   uds_i,
	input  logic                   lds_i,
	input  st_mem_pkg::mem_word_t  ram_din_i,
	input  logic [2:0]             mem_size_i,
	mem_port_if.requester          port
);

	logic                   ras_q;
	logic                   req_q;
	logic                   in_window;
	logic                   ras_fall;
	logic                   we_q;
	logic [1:0]             ds_q;
	st_mem_pkg::word_addr_t addr_q;
	st_mem_pkg::mem_word_t  din_q;

	assign ras_fall = ras_q & ~ras_n_i;

	////////////////////////////////////////
	// size window
	////////////////////////////////////////

	// word bit 22 is byte bit 23
	always_comb begin
		case (mem_size_i)
			st_mem_pkg::MEM_512K: in_window = (ram_addr_i[22:18] == '0);
			st_mem_pkg::MEM_1M:   in_window = (ram_addr_i[22:19] == '0);
			st_mem_pkg::MEM_2M:   in_window = (ram_addr_i[22:20] == '0);
			st_mem_pkg::MEM_4M:   in_window = (ram_addr_i[22:21] == '0);
			st_mem_pkg::MEM_8M:   in_window = ~ram_addr_i[22];
			// below C00000 plus C00000..DFFFFF
			st_mem_pkg::MEM_14M:  in_window = (ram_addr_i[22:20] != 3'b111);
			default:              in_window = 1'b0;
		endcase
	end

	// address zero on a row strobe means refresh
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			ras_q <= 1'b1;
			req_q <= 1'b0;
		end else begin
			ras_q <= ras_n_i;
			req_q <= ras_fall & (|ram_addr_i) & in_window;
		end
	end

	// access fields captured with the strobe
	always_ff @(posedge clk_32) begin
		if (ras_fall) begin
			we_q   <= ~we_n_i;
			ds_q   <= {uds_i, lds_i};
			addr_q <= ram_addr_i;
			din_q  <= ram_din_i;
		end
	end

	assign port.req  = req_q;
	assign port.we   = we_q;
	assign port.addr = addr_q;
	assign port.ds   = ds_q;
	assign port.din  = din_q;

endmodule

/* src/upload_loader.sv */
// host upload path: turns download strobes into byte-swapped word writes
// base address from the download index, or a custom pointer for index 4
`timescale 1ns/10ps

module upload_loader (
	input  logic                   clk_32,
	input  logic                   xsint,
	input  logic                   ioctl_download_i,
	input  logic                   ioctl_wr_i,
	input  logic [4:0]             ioctl_index_i,
	input  logic [24:0]            ioctl_addr_i,
	input  st_mem_pkg::mem_word_t  ioctl_dout_i,
	output logic                   download_o,
	output st_mem_pkg::word_addr_t load_addr_o,
	mem_port_if.requester          port
);

	logic                   dl_q;
	logic                   req_q;
	st_mem_pkg::word_addr_t addr_q;
	st_mem_pkg::word_addr_t base;
	st_mem_pkg::mem_word_t  data_q;
	logic                   start;
	logic                   wr_hit;
	logic                   ptr_word;

	// rising edge of the download level
	assign start  = ioctl_download_i & ~dl_q;
	assign wr_hit = ioctl_wr_i & ioctl_download_i;

	// first two words of a custom upload carry the pointer
	assign ptr_word = (ioctl_index_i == st_mem_pkg::DL_CUSTOM) &&
	                  (ioctl_addr_i[24:2] == '0);

	always_comb begin
		case (ioctl_index_i)
			st_mem_pkg::DL_TOS256: base = st_mem_pkg::BASE_TOS256;
			st_mem_pkg::DL_TOS192: base = st_mem_pkg::BASE_TOS192;
			st_mem_pkg::DL_CART:   base = st_mem_pkg::BASE_CART;
			// clear memory and unknown indexes start at zero
			default:               base = '0;
		endcase
	end

	////////////////////////////////////////
	// address tracking
	////////////////////////////////////////

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			dl_q   <= 1'b0;
			req_q  <= 1'b0;
			addr_q <= '0;
		end else begin
			dl_q  <= ioctl_download_i;
			req_q <= 1'b0;
			// one word below base, first write pre-increments
			if (start && ioctl_index_i != st_mem_pkg::DL_CUSTOM)
				addr_q <= base - 1'b1;
			if (wr_hit) begin
				if (ptr_word) begin
					// low word first, then high bits
					// byte bit 24 lies outside the word address
					if (ioctl_addr_i == '0)
						addr_q[15:0] <= ioctl_dout_i;
					else
						addr_q <= {ioctl_dout_i[6:0], addr_q[15:0]} - 1'b1;
				end else begin
					addr_q <= addr_q + 1'b1;
					req_q  <= 1'b1;
				end
			end
		end
	end

	// host sends little endian words
	always_ff @(posedge clk_32) begin
		if (wr_hit && !ptr_word)
			data_q <= {ioctl_dout_i[7:0], ioctl_dout_i[15:8]};
	end

	assign download_o  = dl_q;
	assign load_addr_o = addr_q;

	// always a full word write
	assign port.req  = req_q;
	assign port.we   = 1'b1;
	assign port.addr = addr_q;
	assign port.ds   = 2'b11;
	assign port.din  = data_q;

endmodule

/* src/mem_port_if.sv */
// one requester's path toward the memory arbiter
// single-cycle req strobe, other fields valid in that same clock
`timescale 1ns/10ps

interface mem_port_if;

	// request strobe, one clock wide
	logic req;
	// write when high, read otherwise
	logic we;
	st_mem_pkg::word_addr_t addr;
	// upper and lower byte strobes
	logic [1:0] ds;
	// write data
	st_mem_pkg::mem_word_t din;

	// peer that starts accesses
	modport requester (
		output req, we, addr, ds, din
	);

	// arbiter side
	modport grant (
		input req, we, addr, ds, din
	);

endinterface

/* src/st_mem_pkg.sv */
// shared codes, base addresses and types for the ST memory multiplexer
// referenced by scoped name from every RTL file

package st_mem_pkg;

	////////////////////////////////////////
	// memory size setting
	////////////////////////////////////////

	typedef enum logic [2:0] {
		MEM_512K = 3'd0,
		MEM_1M   = 3'd1,
		MEM_2M   = 3'd2,
		MEM_4M   = 3'd3,
		MEM_8M   = 3'd4,
		MEM_14M  = 3'd5
	} mem_size_e;

	// host download index, low five bits of the ioctl index
	typedef enum logic [4:0] {
		DL_TOS256 = 5'd0,
		DL_TOS192 = 5'd1,
		DL_CART   = 5'd2,
		DL_CLEAR  = 5'd3,
		DL_CUSTOM = 5'd4
	} dl_index_e;

	// word address covers byte address bits 23..1
	typedef logic [22:0] word_addr_t;
	typedef logic [15:0] mem_word_t;

	// region starts as word addresses
	// E00000, FC0000 and FA0000 in bytes
	localparam word_addr_t BASE_TOS256 = 23'h700000;
	localparam word_addr_t BASE_TOS192 = 23'h7E0000;
	localparam word_addr_t BASE_CART   = 23'h7D0000;

	////////////////////////////////////////
	// bus cycle slots
	////////////////////////////////////////

	localparam logic [1:0] SLOT_PRE     = 2'd0;
	localparam logic [1:0] SLOT_CPU     = 2'd1;
	localparam logic [1:0] SLOT_SHIFTER = 2'd2;
	localparam logic [1:0] SLOT_SPARE   = 2'd3;

endpackage
